// ==== common/dct_pkg.sv ====
/*
 * Shared definitions for the 8x8 Cr forward DCT
 * Sample, coefficient, accumulator and basis types, the scaled basis
 * constants, the DC offset, the round_q14 function and the block structs
 */

package dct_pkg;

	localparam int BLOCK_N  = 8;
	localparam int PIX_W    = 8;
	localparam int COEF_W   = 11;
	localparam int ACC_W    = 32;
	localparam int BASIS_W  = 16;

	// Lowest kept bit of a Q14 sum, bit 13 below it decides the rounding
	localparam int ROUND_LSB = 14;

	typedef logic        [PIX_W-1:0]   pixel_t;
	typedef logic signed [COEF_W-1:0]  coef_t;
	typedef logic signed [ACC_W-1:0]   acc_t;
	typedef logic signed [BASIS_W-1:0] basis_t;

	// Basis magnitudes, cos((2n+1)k*pi/16) scaled to 2^13
	localparam basis_t T1  = 16'sd5793;
	localparam basis_t T21 = 16'sd8035;
	localparam basis_t T22 = 16'sd6811;
	localparam basis_t T23 = 16'sd4551;
	localparam basis_t T24 = 16'sd1598;
	localparam basis_t T31 = 16'sd7568;
	localparam basis_t T32 = 16'sd3135;

	// 128 * 8 * T1, the level shift folded into coefficient 0 of every row
	localparam acc_t DC_OFFSET = 32'sd5932032;

	// One basis column, t[k] is T[k][n] for the selected sample n
	typedef struct packed {
		basis_t [0:BLOCK_N-1] t;
	} basis_col_t;

	// Rounded 1-D result of one row, tagged with its row position
	typedef struct packed {
		logic [2:0]          row_idx;
		coef_t [0:BLOCK_N-1] coef;
	} row_result_t;

	typedef coef_t [0:BLOCK_N-1][0:BLOCK_N-1] block_t;

	// Keep bits 24..14 and round half up on bit 13
	function automatic coef_t round_q14(input acc_t sum);
		coef_t kept;
		kept = coef_t'(sum[ROUND_LSB +: COEF_W]);
		return kept + coef_t'(sum[ROUND_LSB-1]);
	endfunction

endpackage

// ==== dct/dct_basis_rom.sv ====
/*
 * Basis column lookup
 * Returns T[k][idx] for k = 0..7 from the package constants
 */

`timescale 1ns/10ps

module dct_basis_rom (
	input  logic [2:0]          idx,
	output dct_pkg::basis_col_t col
);
	import dct_pkg::*;

	// Each entry lists T[0][n] up to T[7][n]
	always_comb begin
		case (idx)
			3'd0: begin
				col.t = '{T1, T21, T31, T22, T1, T23, T32, T24};
			end
			3'd1: begin
				col.t = '{T1, T22, T32, -T24, -T1, -T21, -T31, -T23};
			end
			3'd2: begin
				col.t = '{T1, T23, -T32, -T21, -T1, T24, T31, T22};
			end
			3'd3: begin
				col.t = '{T1, T24, -T31, -T23, T1, T22, -T32, -T21};
			end
			3'd4: begin
				col.t = '{T1, -T24, -T31, T23, T1, -T22, -T32, T21};
			end
			3'd5: begin
				col.t = '{T1, -T23, -T32, T21, -T1, -T24, T31, -T22};
			end
			3'd6: begin
				col.t = '{T1, -T22, T32, T24, -T1, T21, -T31, T23};
			end
			default: begin
				// Sample 7, mirror of sample 0 with odd rows negated
				col.t = '{T1, -T21, T31, -T22, T1, -T23, T32, -T24};
			end
		endcase
	end

endmodule

// ==== dct/dct_row_stage.sv ====
/*
 * Row stage of the 8x8 DCT
 * Pixel and row counting, the 1-D transform of each row, the DC offset
 * on coefficient 0 and rounding to 11 bits
 */

`timescale 1ns/10ps

module dct_row_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  dct_pkg::pixel_t      data_in,
	output logic                 row_valid,
	output dct_pkg::row_result_t row_out
);
	import dct_pkg::*;

	logic [2:0]            pix_cnt;
	logic [2:0]            row_cnt;
	logic                  row_last;
	logic signed [PIX_W:0] pix_s;
	basis_col_t            basis;
	acc_t [0:BLOCK_N-1]    prod;
	acc_t [0:BLOCK_N-1]    acc;
	acc_t                  dc_sum;

	// Column of the basis for the current sample position
	dct_basis_rom u_basis (
		.idx (pix_cnt),
		.col (basis)
	);

	assign pix_s = signed'({1'b0, data_in});

	always_comb begin
		for (int k = 0; k < BLOCK_N; k++) begin
			prod[k] = acc_t'(pix_s) * acc_t'(basis.t[k]);
		end
	end

	// Dropping enable abandons the partial row and block
	always_ff @(posedge clk) begin
		if (rst) begin
			pix_cnt  <= '0;
			row_cnt  <= '0;
			row_last <= 1'b0;
		end else if (!enable) begin
			pix_cnt  <= '0;
			row_cnt  <= '0;
			row_last <= 1'b0;
		end else begin
			pix_cnt  <= pix_cnt + 3'd1;
			row_last <= (pix_cnt == 3'd7);
			if (pix_cnt == 3'd7) begin
				row_cnt <= row_cnt + 3'd1;
			end
		end
	end

	// Pixel 0 starts a fresh sum
	always_ff @(posedge clk) begin
		if (enable) begin
			for (int k = 0; k < BLOCK_N; k++) begin
				if (pix_cnt == 3'd0) begin
					acc[k] <= prod[k];
				end else begin
					acc[k] <= acc[k] + prod[k];
				end
			end
		end
	end

	// Level shift of the row, only the flat basis row sees it
	assign dc_sum = acc[0] - DC_OFFSET;

	always_ff @(posedge clk) begin
		if (rst) begin
			row_valid <= 1'b0;
		end else begin
			row_valid <= row_last;
		end
	end

	// row_cnt has already stepped past the finished row here
	always_ff @(posedge clk) begin
		if (row_last) begin
			row_out.row_idx <= row_cnt - 3'd1;
			row_out.coef[0] <= round_q14(dc_sum);
			for (int k = 1; k < BLOCK_N; k++) begin
				row_out.coef[k] <= round_q14(acc[k]);
			end
		end
	end

	// A row takes 8 samples, so two strobes can never touch
	assert property (@(posedge clk) disable iff (rst) row_valid |=> !row_valid);

endmodule

// ==== dct/dct_col_stage.sv ====
/*
 * Column stage of the 8x8 DCT
 * Accumulates row results against the transposed basis, rounds the
 * 64 sums and presents the block with a one-cycle pulse
 */

`timescale 1ns/10ps

module dct_col_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 row_valid,
	input  dct_pkg::row_result_t row_in,
	output dct_pkg::block_t      z_final,
	output logic                 output_enable
);
	import dct_pkg::*;

	basis_col_t                      basis;
	acc_t [0:BLOCK_N-1][0:BLOCK_N-1] prod;
	acc_t [0:BLOCK_N-1][0:BLOCK_N-1] acc;
	logic                            blk_done;

	// Row position picks which basis column weights this row
	dct_basis_rom u_basis (
		.idx (row_in.row_idx),
		.col (basis)
	);

	always_comb begin
		for (int i = 0; i < BLOCK_N; i++) begin
			for (int j = 0; j < BLOCK_N; j++) begin
				prod[i][j] = acc_t'(row_in.coef[i]) * acc_t'(basis.t[j]);
			end
		end
	end

	// Row 0 starts a new block and overwrites any aborted one
	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int i = 0; i < BLOCK_N; i++) begin
				for (int j = 0; j < BLOCK_N; j++) begin
					if (row_in.row_idx == 3'd0) begin
						acc[i][j] <= prod[i][j];
					end else begin
						acc[i][j] <= acc[i][j] + prod[i][j];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			blk_done      <= 1'b0;
			output_enable <= 1'b0;
		end else begin
			blk_done      <= row_valid && (row_in.row_idx == 3'd7);
			output_enable <= blk_done;
		end
	end

	// Result held until the next full block
	always_ff @(posedge clk) begin
		if (rst) begin
			z_final <= '0;
		end else if (blk_done) begin
			for (int i = 0; i < BLOCK_N; i++) begin
				for (int j = 0; j < BLOCK_N; j++) begin
					z_final[i][j] <= round_q14(acc[i][j]);
				end
			end
		end
	end

	// Pulse comes two cycles after row 7 of a block whose row 6 came one row time earlier
	assert property (@(posedge clk) disable iff (rst)
		output_enable |-> $past(row_valid && (row_in.row_idx == 3'd7), 2)
			&& $past(row_valid && (row_in.row_idx == 3'd6), 10));

endmodule

// ==== dct/cr_dct.sv ====
/*
 * Cr channel 8x8 forward DCT
 * Row stage feeding the column stage
 */

`timescale 1ns/10ps

module cr_dct (
	input  logic            clk,
	input  logic            rst,
	input  logic            enable,
	input  dct_pkg::pixel_t data_in,
	output dct_pkg::block_t z_final,
	output logic            output_enable
);
	import dct_pkg::*;

	logic        row_valid;
	row_result_t row_res;

	dct_row_stage u_row (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.row_valid (row_valid),
		.row_out   (row_res)
	);

	dct_col_stage u_col (
		.clk           (clk),
		.rst           (rst),
		.row_valid     (row_valid),
		.row_in        (row_res),
		.z_final       (z_final),
		.output_enable (output_enable)
	);

endmodule

// ==== verification/tb_cr_dct.sv ====
/*
 * Testbench for the Cr 8x8 forward DCT
 * Clock and reset, stimulus and expected blocks read from the data file,
 * output checks on each output_enable pulse, watchdog and final report
 */

`timescale 1ns/10ps

module tb_cr_dct;
	import dct_pkg::*;

	localparam int MAX_BLK    = 64;
	localparam int MAX_TEST   = 16;
	localparam int RST_CYCLES = 5;
	localparam int CLK_PERIOD = 40;
	localparam int PULSE_LAT  = 3;

	logic   clk;
	logic   rst;
	logic   enable;
	pixel_t data_in;
	block_t z_final;
	logic   output_enable;

	logic [7:0]   pix_mem [0:MAX_BLK*64-1];
	logic [10:0]  exp_mem [0:MAX_BLK*64-1];
	logic [255:0] test_name [0:MAX_TEST-1];
	int           test_blocks [0:MAX_TEST-1];
	int           test_abort [0:MAX_TEST-1];
	int           test_first [0:MAX_TEST-1];
	int           n_tests = 0;
	int           n_blocks = 0;
	bit           loaded = 1'b0;
	int           cycle = 0;
	int           err_cnt = 0;
	int           pulse_cnt = 0;
	bit           seen_pulse = 1'b0;
	bit           zero_reported = 1'b0;
	int           due_q [$];
	int           blk_q [$];

	cr_dct dut0 (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.z_final       (z_final),
		.output_enable (output_enable)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// Control token, then per block 64 pixels and 64 expected coefficients
	task automatic load_tests();
		int           fd;
		int           rc;
		int           bad;
		logic [255:0] tok;
		logic [7:0]   pv;
		logic [10:0]  ev;
		string        skip;
		bad = 0;
		fd = $fopen("verification/dct_input.txt", "r");
		if (fd == 0) begin
			$display("Stimulus file verification/dct_input.txt could not be opened");
			err_cnt++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					rc = $fgets(skip, fd);
				end else begin
					test_name[n_tests] = tok;
					rc = $fscanf(fd, "%d %d", test_blocks[n_tests], test_abort[n_tests]);
					if (rc != 2) begin
						bad++;
					end
					test_first[n_tests] = n_blocks;
					for (int b = 0; b < test_blocks[n_tests]; b++) begin
						for (int i = 0; i < 64; i++) begin
							rc = $fscanf(fd, "%h", pv);
							if (rc != 1) begin
								bad++;
							end
							pix_mem[n_blocks*64+i] = pv;
						end
						for (int i = 0; i < 64; i++) begin
							rc = $fscanf(fd, "%h", ev);
							if (rc != 1) begin
								bad++;
							end
							exp_mem[n_blocks*64+i] = ev;
						end
						n_blocks++;
					end
					n_tests++;
				end
			end
			$fclose(fd);
			if (bad > 0) begin
				$display("Stimulus file has %0d missing or malformed entries", bad);
				err_cnt++;
			end
		end
	endtask

	// The last pixel of a full block books one pulse
	// cycle still shows the previous edge here and the pixel is sampled one edge later
	task automatic send_pixels(input int blk, input int count, input bit full);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			enable  <= 1'b1;
			data_in <= pix_mem[blk*64+i];
			if (full && i == 63) begin
				due_q.push_back(cycle + 2 + PULSE_LAT);
				blk_q.push_back(blk);
			end
		end
	endtask

	task automatic compare_block(input int blk);
		for (int i = 0; i < BLOCK_N; i++) begin
			for (int j = 0; j < BLOCK_N; j++) begin
				assert (z_final[i][j] == exp_mem[blk*64+i*8+j]) else begin
					$display("[ERROR] z_final[%0d][%0d] expected %03h actual %03h",
						i, j, exp_mem[blk*64+i*8+j], z_final[i][j]);
					err_cnt++;
				end
			end
		end
	endtask

	// Outputs are read on the falling edge when they are stable
	always @(negedge clk) begin
		if (!seen_pulse && !output_enable && !zero_reported) begin
			assert (z_final == '0) else begin
				$display("z_final is not zero before the first block completed");
				err_cnt++;
				zero_reported = 1'b1;
			end
		end
		if (output_enable) begin
			pulse_cnt++;
			seen_pulse = 1'b1;
			assert (due_q.size() > 0) else begin
				$display("Unexpected output_enable pulse at cycle %0d", cycle);
				err_cnt++;
			end
			if (due_q.size() > 0) begin
				assert (cycle == due_q[0]) else begin
					$display("Pulse for block %0d came at cycle %0d instead of %0d",
						blk_q[0], cycle, due_q[0]);
					err_cnt++;
				end
				compare_block(blk_q[0]);
				void'(due_q.pop_front());
				void'(blk_q.pop_front());
			end
		end else if (due_q.size() > 0) begin
			assert (cycle <= due_q[0]) else begin
				$display("No output_enable pulse for block %0d", blk_q[0]);
				err_cnt++;
				void'(due_q.pop_front());
				void'(blk_q.pop_front());
			end
		end
	end

	initial begin
		int limit;
		wait (loaded);
		limit = RST_CYCLES + 10 * n_tests;
		for (int t = 0; t < n_tests; t++) begin
			limit += test_abort[t] + 64 * test_blocks[t];
		end
		#(limit * CLK_PERIOD);
		$display("Watchdog timeout, the run did not end within %0d cycles", limit);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		int first_err;
		rst     = 1'b1;
		enable  = 1'b0;
		data_in = '0;
		load_tests();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < n_tests; t++) begin
			first_err = err_cnt;
			if (test_abort[t] > 0) begin
				send_pixels(test_first[t], test_abort[t], 1'b0);
				@(posedge clk);
				enable <= 1'b0;
			end
			for (int b = 0; b < test_blocks[t]; b++) begin
				send_pixels(test_first[t] + b, 64, 1'b1);
			end
			@(posedge clk);
			enable <= 1'b0;
			while (due_q.size() > 0) @(negedge clk);
			$display("Test %0s: %0s, %0d errors", test_name[t],
				(err_cnt == first_err) ? "pass" : "fail", err_cnt - first_err);
		end
		$display("Tests %0d, blocks %0d, pulses %0d, errors %0d",
			n_tests, n_blocks, pulse_cnt, err_cnt);
		if (err_cnt == 0 && n_tests > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== verification/dct_input.txt ====
# Control line: test_name block_count abort_pos (pixels sent before enable drops, 0 = none)
# Per block: 64 pixel bytes, then 64 expected 11-bit coefficients z[i][j], row major, hex
const128 1 0
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
const255 1 0
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
3f7 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
varied 2 0
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
7fc 39c 000 6bc 000 0d9 000 748 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00
7fd 000 000 000 000 000 000 000 39d 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 6bb 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 0da 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 748 000 000 000 000 000 000 000
back_to_back 3 0
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
400 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
7fc 39c 000 6bc 000 0d9 000 748 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
3f7 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
abort 1 37
ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00 ff ff ff ff 00 00 00 00
7fd 000 000 000 000 000 000 000 39d 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 6bb 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 0da 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 748 000 000 000 000 000 000 000

// ==== filelist.f ====
common/dct_pkg.sv
dct/dct_basis_rom.sv
dct/dct_row_stage.sv
dct/dct_col_stage.sv
dct/cr_dct.sv
verification/tb_cr_dct.sv

// ==== Makefile ====
# Verilator build and run of the DCT testbench

VERILATOR ?= verilator
TOP       ?= tb_cr_dct
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
